// ==== qm_isa_pkg.sv ====
package qm_isa_pkg;

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////

	typedef logic [6:0] opcode_t;	// Major opcode.
	typedef logic [5:0] func_t;	// Function field of the R3 format.

	// Register-three-operand group.
	localparam opcode_t OP_R3O = 7'h02;

	// Queue operations inside the R3 group.
	localparam func_t FN_RESETQ = 6'h30;
	localparam func_t FN_READQ = 6'h31;
	localparam func_t FN_WRITEQ = 6'h32;

	typedef struct packed {
		opcode_t opcode;
		func_t func;
	} micro_op_t;

	////////////////////////////////////////
	// Reorder buffer and operands
	////////////////////////////////////////

	typedef logic [2:0] rob_id_t;
	typedef logic [7:0] rob_bitmask_t;	// One bit per ROB slot.
	typedef logic [63:0] word_t;

	// arg1 holds the queue number, arg2 the data to be written.
	typedef struct packed {
		rob_id_t rob_id;
		word_t arg0;
		word_t arg1;
		word_t arg2;
	} rs_entry_t;

	////////////////////////////////////////
	// Write-back
	////////////////////////////////////////

	// Low eight bits are byte lanes; bit 8 is the tag bit and stays clear.
	typedef logic [8:0] byte_en_t;

	localparam byte_en_t BE_NONE = 9'h000;
	localparam byte_en_t BE_WORD = 9'h0ff;	// All eight data bytes.

endpackage

// ==== qm_queue_pkg.sv ====
package qm_queue_pkg;

	////////////////////////////////////////
	// Queue geometry
	////////////////////////////////////////

	localparam int QUEUE_COUNT = 4;
	localparam int QUEUE_DEPTH = 8;	// A power of two, so the pointers wrap by themselves.
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [1:0] queue_id_t;
	typedef logic [QPTR_W-1:0] qptr_t;
	typedef logic [QCNT_W-1:0] qcnt_t;

	////////////////////////////////////////
	// Commands and returns
	////////////////////////////////////////

	typedef enum logic [1:0] {
		QOP_NONE,
		QOP_RESET,
		QOP_POP,
		QOP_PUSH
	} queue_op_t;

	typedef struct packed {
		queue_op_t op;
		queue_id_t qid;
		qm_isa_pkg::word_t data;
	} queue_cmd_t;

	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_QUEUE_EMPTY,
		EXC_QUEUE_FULL
	} exc_code_t;

	// Data is zero when the pop found the queue empty.
	typedef struct packed {
		logic valid;
		logic empty;
		qm_isa_pkg::word_t data;
	} read_ret_t;

endpackage

// ==== queue_manager.sv ====
`timescale 1ns/1ps

module queue_manager
(
	input logic clk,
	input logic rst,
	input logic issue_i,
	input qm_isa_pkg::rs_entry_t rse_i,
	input qm_isa_pkg::micro_op_t ir_i,
	input qm_isa_pkg::rob_bitmask_t stomp_i,
	output qm_isa_pkg::rs_entry_t rse_o,
	output qm_queue_pkg::queue_cmd_t cmd_o,
	output logic push_done_o
);
	import qm_isa_pkg::*;
	import qm_queue_pkg::*;

	logic is_queue_grp;
	logic stomped;
	logic live;
	logic dec_reset;
	logic dec_pop;
	logic dec_push;
	queue_op_t next_op;
	queue_id_t next_qid;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	assign is_queue_grp = (ir_i.opcode == OP_R3O);
	assign stomped = stomp_i[rse_i.rob_id];	// The ROB slot was flushed this cycle.
	assign live = issue_i && is_queue_grp && !stomped;

	assign dec_reset = live && (ir_i.func == FN_RESETQ);
	assign dec_pop = live && (ir_i.func == FN_READQ);
	assign dec_push = live && (ir_i.func == FN_WRITEQ);

	// Only the low bits of arg1 select a queue.
	assign next_qid = rse_i.arg1[$bits(queue_id_t)-1:0];

	always_comb
	begin
		next_op = QOP_NONE;
		if (dec_reset)
			next_op = QOP_RESET;
		else if (dec_pop)
			next_op = QOP_POP;
		else if (dec_push)
			next_op = QOP_PUSH;
	end

	////////////////////////////////////////
	// Command register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		cmd_o.qid <= next_qid;
		cmd_o.data <= rse_i.arg2;
		if (rst)
		begin
			cmd_o.op <= QOP_NONE;
			push_done_o <= 1'b0;
		end
		else
		begin
			cmd_o.op <= next_op;
			// Resets and pushes complete without waiting for data.
			push_done_o <= dec_reset || dec_push;
		end
	end

	// The entry follows the command by one stage.
	always_ff @(posedge clk)
	begin
		rse_o <= rse_i;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	assert property (@(posedge clk) disable iff (rst)
		$onehot0({dec_reset, dec_pop, dec_push}));

endmodule

// ==== queue_bank.sv ====
`timescale 1ns/1ps

module queue_bank
(
	input logic clk,
	input logic rst,
	input qm_queue_pkg::queue_cmd_t cmd_i,
	output qm_queue_pkg::read_ret_t read_ret_o,
	output logic push_full_o
);
	import qm_isa_pkg::*;
	import qm_queue_pkg::*;

	qcnt_t count [QUEUE_COUNT];
	word_t head_word [QUEUE_COUNT];
	logic sel_empty;
	logic sel_full;

	////////////////////////////////////////
	// Queue storage
	////////////////////////////////////////

	for (genvar g = 0; g < QUEUE_COUNT; g++)
	begin : g_queue
		word_t mem [QUEUE_DEPTH];
		qptr_t head;
		qptr_t tail;
		qcnt_t cnt;
		logic sel;
		logic do_reset;
		logic do_pop;
		logic do_push;

		assign sel = (cmd_i.qid == queue_id_t'(g));
		assign do_reset = sel && (cmd_i.op == QOP_RESET);
		assign do_pop = sel && (cmd_i.op == QOP_POP) && (cnt != '0);
		assign do_push = sel && (cmd_i.op == QOP_PUSH) && (cnt != qcnt_t'(QUEUE_DEPTH));

		always_ff @(posedge clk)
		begin
			if (rst || do_reset)
			begin
				head <= '0;
				tail <= '0;
				cnt <= '0;
			end
			else if (do_push)
			begin
				tail <= tail + 1'b1;
				cnt <= cnt + 1'b1;
			end
			else if (do_pop)
			begin
				head <= head + 1'b1;
				cnt <= cnt - 1'b1;
			end
		end

		always_ff @(posedge clk)
		begin
			if (do_push)
				mem[tail] <= cmd_i.data;
		end

		assign count[g] = cnt;
		assign head_word[g] = mem[head];	// Oldest entry.

		assert property (@(posedge clk) disable iff (rst)
			cnt <= qcnt_t'(QUEUE_DEPTH));
	end

	////////////////////////////////////////
	// Read return and full flag
	////////////////////////////////////////

	assign sel_empty = (count[cmd_i.qid] == '0);
	assign sel_full = (count[cmd_i.qid] == qcnt_t'(QUEUE_DEPTH));

	always_ff @(posedge clk)
	begin
		read_ret_o.data <= '0;
		if (cmd_i.op == QOP_POP && !sel_empty)
			read_ret_o.data <= head_word[cmd_i.qid];
		if (rst)
		begin
			read_ret_o.valid <= 1'b0;
			read_ret_o.empty <= 1'b0;
			push_full_o <= 1'b0;
		end
		else
		begin
			read_ret_o.valid <= (cmd_i.op == QOP_POP);
			read_ret_o.empty <= (cmd_i.op == QOP_POP) && sel_empty;
			push_full_o <= (cmd_i.op == QOP_PUSH) && sel_full;	// Push is dropped.
		end
	end

endmodule

// ==== queue_result.sv ====
`timescale 1ns/1ps

module queue_result
(
	input logic clk,
	input logic rst,
	input qm_queue_pkg::read_ret_t read_ret_i,
	input logic push_done_i,
	input logic push_full_i,
	output qm_isa_pkg::word_t result_o,
	output qm_isa_pkg::byte_en_t we_o,
	output logic done_o,
	output qm_queue_pkg::exc_code_t exc_o
);
	import qm_isa_pkg::*;
	import qm_queue_pkg::*;

	read_ret_t ret_q;
	logic push_done_q;

	////////////////////////////////////////
	// Alignment stage
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		ret_q.data <= read_ret_i.data;
		if (rst)
		begin
			ret_q.valid <= 1'b0;
			ret_q.empty <= 1'b0;
			push_done_q <= 1'b0;
		end
		else
		begin
			ret_q.valid <= read_ret_i.valid;
			ret_q.empty <= read_ret_i.empty;
			push_done_q <= push_done_i;	// Lines up with the bank's full flag.
		end
	end

	////////////////////////////////////////
	// Write-back
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result_o <= '0;
			we_o <= BE_NONE;
			done_o <= 1'b0;
			exc_o <= EXC_NONE;
		end
		else
		begin
			done_o <= ret_q.valid || push_done_q;
			result_o <= ret_q.valid ? ret_q.data : '0;
			we_o <= (ret_q.valid && !ret_q.empty) ? BE_WORD : BE_NONE;
			// A pop finishing alongside a push reports its own exception first.
			if (ret_q.valid && ret_q.empty)
				exc_o <= EXC_QUEUE_EMPTY;
			else if (push_full_i)
				exc_o <= EXC_QUEUE_FULL;
			else
				exc_o <= EXC_NONE;
		end
	end

	assert property (@(posedge clk) disable iff (rst) (we_o != BE_NONE) |-> done_o);

	// The bank only flags a full queue for a push the manager has completed.
	assert property (@(posedge clk) disable iff (rst) push_full_i |-> push_done_q);

endmodule

// ==== queue_unit_top.sv ====
`timescale 1ns/1ps

module queue_unit_top
(
	input logic clk,
	input logic rst,
	input logic issue_i,
	input qm_isa_pkg::rs_entry_t rse_i,
	input qm_isa_pkg::micro_op_t ir_i,
	input qm_isa_pkg::rob_bitmask_t stomp_i,
	output qm_isa_pkg::rs_entry_t rse_o,
	output qm_isa_pkg::word_t result_o,
	output qm_isa_pkg::byte_en_t we_o,
	output logic done_o,
	output qm_queue_pkg::exc_code_t exc_o
);
	import qm_queue_pkg::*;

	queue_cmd_t cmd;
	logic push_done;
	read_ret_t read_ret;
	logic push_full;

	queue_manager u_manager (
		.clk(clk),
		.rst(rst),
		.issue_i(issue_i),
		.rse_i(rse_i),
		.ir_i(ir_i),
		.stomp_i(stomp_i),
		.rse_o(rse_o),
		.cmd_o(cmd),
		.push_done_o(push_done)
	);

	queue_bank u_bank (
		.clk(clk),
		.rst(rst),
		.cmd_i(cmd),
		.read_ret_o(read_ret),
		.push_full_o(push_full)
	);

	queue_result u_result (
		.clk(clk),
		.rst(rst),
		.read_ret_i(read_ret),
		.push_done_i(push_done),
		.push_full_i(push_full),
		.result_o(result_o),
		.we_o(we_o),
		.done_o(done_o),
		.exc_o(exc_o)
	);

endmodule

// ==== tb_queue_unit.sv ====
`timescale 1ns/1ps

module tb_queue_unit;
	import qm_isa_pkg::*;
	import qm_queue_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int OP_CYCLES = 6;	// Longest run_op call, issue to last check.
	localparam int TEST_OPS = 4 + 16 + 18 + 6 + 8 + 6;	// Operations per test, in order.
	localparam int WATCHDOG_CYCLES = 3 + OP_CYCLES * TEST_OPS + 100;

	logic clk = 1'b0;
	logic rst;
	logic issue_i;
	rs_entry_t rse_i;
	micro_op_t ir_i;
	rob_bitmask_t stomp_i;
	rs_entry_t rse_o;
	word_t result_o;
	byte_en_t we_o;
	logic done_o;
	exc_code_t exc_o;

	word_t model_q [QUEUE_COUNT][$];	// Expected contents, oldest first.
	word_t lcg_state = 64'd63;
	rob_id_t rob_next = '0;
	int checks = 0;
	int errors = 0;

	queue_unit_top uut (
		.clk(clk),
		.rst(rst),
		.issue_i(issue_i),
		.rse_i(rse_i),
		.ir_i(ir_i),
		.stomp_i(stomp_i),
		.rse_o(rse_o),
		.result_o(result_o),
		.we_o(we_o),
		.done_o(done_o),
		.exc_o(exc_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic word_t next_random();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	function automatic rs_entry_t make_entry(input queue_id_t q, input word_t data);
		rs_entry_t ent;
		ent.rob_id = rob_next;
		ent.arg0 = next_random();	// Unused by the unit, only travels to rse_o.
		ent.arg1 = word_t'(q);
		ent.arg2 = data;
		rob_next = rob_next + 3'd1;
		return ent;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: result expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
		checks++;
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: we expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_exc(input string name, input exc_code_t exp, input exc_code_t act);
		checks++;
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: exc expected %s, actual %s (%0d)",
				name, exp.name(), act.name(), act));
	endtask

	task automatic check_entry(input string name, input rs_entry_t exp, input rs_entry_t act);
		checks++;
		if (act !== exp)
			report_error($sformatf("[FAIL] %s: rse_o expected %h, actual %h", name, exp, act));
	endtask

	task automatic issue(input opcode_t opc, input func_t fn, input rs_entry_t ent,
		input rob_bitmask_t stomp);
		@(posedge clk);
		issue_i <= 1'b1;
		ir_i.opcode <= opc;
		ir_i.func <= fn;
		rse_i <= ent;
		stomp_i <= stomp;
	endtask

	task automatic idle();
		@(posedge clk);
		issue_i <= 1'b0;
		stomp_i <= '0;
	endtask

	// Issues one micro-op and checks its completion against the queue model.
	task automatic run_op(input string name, input opcode_t opc, input func_t fn,
		input queue_id_t q, input word_t data, input logic stomp);
		rs_entry_t ent;
		rob_bitmask_t stomp_mask;
		logic live;
		int latency;
		word_t exp_word;
		byte_en_t exp_be;
		exc_code_t exp_exc;
		ent = make_entry(q, data);
		live = (opc == OP_R3O) && !stomp &&
			(fn == FN_RESETQ || fn == FN_READQ || fn == FN_WRITEQ);
		latency = !live ? 5 : (fn == FN_READQ ? 4 : 3);
		exp_word = '0;
		exp_be = 9'h000;
		exp_exc = EXC_NONE;
		if (live && fn == FN_RESETQ)
			model_q[q].delete();
		else if (live && fn == FN_WRITEQ)
		begin
			if (model_q[q].size() == QUEUE_DEPTH)
				exp_exc = EXC_QUEUE_FULL;	// Queue stays as it is.
			else
				model_q[q].push_back(data);
		end
		else if (live && fn == FN_READQ)
		begin
			if (model_q[q].size() == 0)
				exp_exc = EXC_QUEUE_EMPTY;
			else
			begin
				exp_word = model_q[q].pop_front();
				exp_be = 9'h0ff;
			end
		end
		// Other ROB slots are flushed too; only the entry's own bit may cancel it.
		stomp_mask = '0;
		stomp_mask[ent.rob_id] = 1'b1;
		if (!stomp)
			stomp_mask = ~stomp_mask;
		issue(opc, fn, ent, stomp_mask);
		idle();
		for (int i = 1; i <= latency; i++)
		begin
			@(negedge clk);
			if (done_o !== 1'b0 && (i < latency || !live))
				report_error($sformatf("%s: done_o went high at an unexpected cycle", name));
		end
		if (live)
		begin
			if (done_o !== 1'b1)
				report_error($sformatf("%s: done_o did not go high on time", name));
			check_word(name, exp_word, result_o);
			check_be(name, exp_be, we_o);
			check_exc(name, exp_exc, exc_o);
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset_state();
		@(negedge clk);
		if (done_o !== 1'b0)
			report_error("reset_state: done_o is not low after reset");
		check_word("reset_state", '0, result_o);
		check_be("reset_state", 9'h000, we_o);
		check_exc("reset_state", EXC_NONE, exc_o);
		for (int q = 0; q < QUEUE_COUNT; q++)
			run_op("reset_state", OP_R3O, FN_READQ, queue_id_t'(q), '0, 1'b0);
	endtask

	task automatic test_fifo_order();
		for (int q = 0; q < QUEUE_COUNT; q++)
			for (int n = 0; n < 2; n++)
				run_op("fifo_order", OP_R3O, FN_WRITEQ, queue_id_t'(q), next_random(), 1'b0);
		for (int q = 0; q < QUEUE_COUNT; q++)
			for (int n = 0; n < 2; n++)
				run_op("fifo_order", OP_R3O, FN_READQ, queue_id_t'(q), '0, 1'b0);
	endtask

	task automatic test_full_queue();
		for (int n = 0; n < QUEUE_DEPTH + 1; n++)
			run_op("full_queue", OP_R3O, FN_WRITEQ, 2'd1, next_random(), 1'b0);
		for (int n = 0; n < QUEUE_DEPTH + 1; n++)
			run_op("full_queue", OP_R3O, FN_READQ, 2'd1, '0, 1'b0);
	endtask

	task automatic test_queue_reset();
		run_op("queue_reset", OP_R3O, FN_WRITEQ, 2'd2, next_random(), 1'b0);
		run_op("queue_reset", OP_R3O, FN_WRITEQ, 2'd2, next_random(), 1'b0);
		run_op("queue_reset", OP_R3O, FN_WRITEQ, 2'd0, next_random(), 1'b0);
		run_op("queue_reset", OP_R3O, FN_RESETQ, 2'd2, '0, 1'b0);
		run_op("queue_reset", OP_R3O, FN_READQ, 2'd2, '0, 1'b0);
		run_op("queue_reset", OP_R3O, FN_READQ, 2'd0, '0, 1'b0);
	endtask

	task automatic test_rejected_ops();
		run_op("rejected_ops", OP_R3O, FN_WRITEQ, 2'd3, next_random(), 1'b0);
		run_op("rejected_ops", OP_R3O, FN_RESETQ, 2'd3, '0, 1'b1);
		run_op("rejected_ops", OP_R3O, FN_READQ, 2'd3, '0, 1'b1);
		run_op("rejected_ops", OP_R3O, FN_WRITEQ, 2'd3, next_random(), 1'b1);
		run_op("rejected_ops", 7'h33, FN_WRITEQ, 2'd3, next_random(), 1'b0);
		run_op("rejected_ops", OP_R3O, 6'h10, 2'd3, next_random(), 1'b0);
		run_op("rejected_ops", OP_R3O, FN_READQ, 2'd3, '0, 1'b0);
		run_op("rejected_ops", OP_R3O, FN_READQ, 2'd3, '0, 1'b0);
	endtask

	task automatic test_back_to_back();
		rs_entry_t ent [3];
		word_t exp_word [3];
		for (int n = 0; n < 3; n++)
			run_op("back_to_back", OP_R3O, FN_WRITEQ, 2'd0, next_random(), 1'b0);
		for (int n = 0; n < 3; n++)
		begin
			ent[n] = make_entry(2'd0, '0);
			exp_word[n] = model_q[0].pop_front();
			issue(OP_R3O, FN_READQ, ent[n], '0);
			if (n > 0)
			begin
				@(negedge clk);
				check_entry("back_to_back", ent[n - 1], rse_o);
			end
		end
		idle();
		@(negedge clk);
		check_entry("back_to_back", ent[2], rse_o);
		for (int n = 0; n < 4; n++)
		begin
			@(negedge clk);
			if (done_o !== (n < 3))
				report_error($sformatf("back_to_back: done_o wrong in cycle %0d of the burst", n));
			if (n < 3)
			begin
				check_word("back_to_back", exp_word[n], result_o);
				check_be("back_to_back", 9'h0ff, we_o);
				check_exc("back_to_back", EXC_NONE, exc_o);
			end
		end
	endtask

	////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////

	initial
	begin
		rst <= 1'b1;
		issue_i <= 1'b0;
		rse_i <= '0;
		ir_i <= '0;
		stomp_i <= '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		test_reset_state();
		test_fifo_order();
		test_full_queue();
		test_queue_reset();
		test_rejected_ops();
		test_back_to_back();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
qm_isa_pkg.sv
qm_queue_pkg.sv
queue_manager.sv
queue_bank.sv
queue_result.sv
queue_unit_top.sv
tb_queue_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_queue_unit -f verilog.f -o sim_queue_unit

out=$(./obj_dir/sim_queue_unit)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Testbench passed"
